// ==== rtl/adc_pkg.sv ====
////////////////////////////////////////
// ADC receiver package
// Widths, sample types, frame pattern and SPI constants
////////////////////////////////////////

`default_nettype none

package adc_pkg;

	////////////////////////////////////////
	// Datapath

	localparam int LANE_BITS = 8;          // Bits per deserialized word
	localparam int NUM_LANES = 5;          // adc0 lo/hi, adc1 lo/hi, frame

	typedef logic [LANE_BITS-1:0] lane_word_t;   // One word of one lane
	typedef logic signed [15:0] sample_t;         // Two's complement sample

	// Frame lane content once the word boundary is right
	localparam lane_word_t FRAME_PATTERN = 8'b11110000;
	localparam int SLIP_SETTLE_WORDS = 4;  // Mismatching words before a slip

	////////////////////////////////////////
	// Control path

	// {write flag (0 = write), reg addr[6:0], data[7:0]}
	typedef logic [15:0] spi_word_t;

	localparam int SPI_HALF_PERIOD = 5;        // clk_in cycles per sck half period
	localparam int POWERUP_WAIT_CYCLES = 256;  // Settle time before first write

	localparam logic [7:0] CMD_WRITE_PREFIX = 8'h31;  // Host register write

	// Init sequence, sent in this order
	localparam spi_word_t INIT_WORD_RESET  = 16'h0080;  // Reg 0, soft reset
	localparam spi_word_t INIT_WORD_FORMAT = 16'h0120;  // Reg 1, two's complement
	localparam spi_word_t INIT_WORD_LANES  = 16'h0200;  // Reg 2, 2-lane output

endpackage

`default_nettype wire

// ==== rtl/lane_word_if.sv ====
////////////////////////////////////////
// Lane word interface
// Deserialized words, strobe and slip between datapath stages
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

interface lane_word_if;
	import adc_pkg::*;

	lane_word_t adc0_lo, adc0_hi;   // ADC0 lane pair
	lane_word_t adc1_lo, adc1_hi;   // ADC1 lane pair
	lane_word_t frame;              // Frame lane
	logic word_valid;               // One cycle per new word set
	logic slip;                     // Move boundary one bit later
	logic aligned;                  // Frame locked, held until reset

	modport deser (output adc0_lo, adc0_hi, adc1_lo, adc1_hi, frame, word_valid,
		input slip);
	modport aligner (input frame, word_valid, output slip, aligned);
	modport unpacker (input adc0_lo, adc0_hi, adc1_lo, adc1_hi, word_valid, aligned);

endinterface

`default_nettype wire

// ==== rtl/lane_deserializer.sv ====
////////////////////////////////////////
// Lane deserializer
// Shifts the five serial lanes into words, boundary moved by slip
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module lane_deserializer (
	input logic clk_in,
	input logic rst_in,
	input logic [adc_pkg::NUM_LANES-1:0] lanes,  // 0/1 adc0 lo/hi, 2/3 adc1 lo/hi, 4 frame
	lane_word_if.deser words
);
	import adc_pkg::*;

	lane_word_t shift_q [NUM_LANES];   // Running window of the last bits
	lane_word_t shift_d [NUM_LANES];
	logic [$clog2(LANE_BITS)-1:0] bit_cnt;
	logic word_end;

	// Oldest bit ends up in bit 7
	always_comb begin
		for (int i = 0; i < NUM_LANES; i++)
			shift_d[i] = {shift_q[i][LANE_BITS-2:0], lanes[i]};
	end

	// A slip holds the counter, so this word ends one bit later
	assign word_end = (bit_cnt == ($clog2(LANE_BITS))'(LANE_BITS - 1)) && !words.slip;

	////////////////////////////////////////
	// Bit counter and strobe

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			bit_cnt <= '0;
			words.word_valid <= 1'b0;
		end else begin
			words.word_valid <= word_end;
			if (!words.slip)
				bit_cnt <= bit_cnt + 1'b1;  // Wraps after the 8th bit
		end
	end

	////////////////////////////////////////
	// Shift registers and word registers

	always_ff @(posedge clk_in) begin
		shift_q <= shift_d;
		if (word_end) begin
			words.adc0_lo <= shift_d[0];
			words.adc0_hi <= shift_d[1];
			words.adc1_lo <= shift_d[2];
			words.adc1_hi <= shift_d[3];
			words.frame <= shift_d[4];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/frame_aligner.sv ====
////////////////////////////////////////
// Frame aligner
// Slips the word boundary until the frame lane shows the pattern
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module frame_aligner (
	input logic clk_in,
	input logic rst_in,
	lane_word_if.aligner words
);
	import adc_pkg::*;

	typedef enum logic [1:0] {
		ALN_CHECK,   // Judge each new frame word
		ALN_SLIP,    // Slip pulse is out
		ALN_LOCKED   // Pattern seen, stay here
	} aln_state_t;

	aln_state_t state;
	logic [$clog2(SLIP_SETTLE_WORDS)-1:0] miss_cnt;  // Mismatches since last slip
	logic frame_match;

	assign frame_match = (words.frame == FRAME_PATTERN);

	////////////////////////////////////////
	// Slip state machine

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state <= ALN_CHECK;
			miss_cnt <= '0;
			words.slip <= 1'b0;
			words.aligned <= 1'b0;
		end else begin
			case (state)
				ALN_CHECK: begin
					if (words.word_valid) begin
						if (frame_match) begin
							words.aligned <= 1'b1;  // Held until reset
							state <= ALN_LOCKED;
						end else if (miss_cnt ==
							($clog2(SLIP_SETTLE_WORDS))'(SLIP_SETTLE_WORDS - 1)) begin
							// Enough bad words at this boundary, try the next bit
							words.slip <= 1'b1;
							miss_cnt <= '0;
							state <= ALN_SLIP;
						end else begin
							miss_cnt <= miss_cnt + 1'b1;
						end
					end
				end
				ALN_SLIP: begin
					words.slip <= 1'b0;  // Single cycle pulse
					state <= ALN_CHECK;
				end
				ALN_LOCKED: begin
					words.slip <= 1'b0;
				end
				default: begin
					state <= ALN_CHECK;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sample_unpacker.sv ====
////////////////////////////////////////
// Sample unpacker
// Interleaves each lane pair into one signed sample per channel
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module sample_unpacker (
	input logic clk_in,
	input logic rst_in,
	lane_word_if.unpacker words,
	output adc_pkg::sample_t adc0_sample,
	output adc_pkg::sample_t adc1_sample,
	output logic sample_valid
);
	import adc_pkg::*;

	// Odd bits come from the lo lane, even bits from the hi lane
	function automatic sample_t interleave(input lane_word_t lo, input lane_word_t hi);
		sample_t s;
		for (int i = 0; i < LANE_BITS; i++) begin
			s[2*i+1] = lo[i];
			s[2*i] = hi[i];
		end
		return s;
	endfunction

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in)
			sample_valid <= 1'b0;
		else
			sample_valid <= words.word_valid && words.aligned;  // Nothing before lock
	end

	always_ff @(posedge clk_in) begin
		if (words.word_valid && words.aligned) begin
			adc0_sample <= interleave(words.adc0_lo, words.adc0_hi);
			adc1_sample <= interleave(words.adc1_lo, words.adc1_hi);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/spi_master.sv ====
////////////////////////////////////////
// SPI master
// Write-only 16-bit mode 0 shifter, MSB first
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module spi_master (
	input logic clk_in,
	input logic rst_in,
	input logic spi_start,
	input adc_pkg::spi_word_t spi_word,
	output logic spi_ready,
	output logic spi_scs,
	output logic spi_sck,
	output logic spi_sdo
);
	import adc_pkg::*;

	typedef enum logic [1:0] {
		SPI_IDLE,
		SPI_SHIFT,   // scs low, sck running
		SPI_DONE     // scs back high, ready next cycle
	} spi_state_t;

	spi_state_t state;
	spi_word_t shift_q;
	logic [$clog2(SPI_HALF_PERIOD)-1:0] div_cnt;
	logic [$clog2($bits(spi_word_t))-1:0] bit_cnt;
	logic half_end, sck_fall, last_bit;

	assign half_end = (state == SPI_SHIFT) &&
		(div_cnt == ($clog2(SPI_HALF_PERIOD))'(SPI_HALF_PERIOD - 1));
	assign sck_fall = half_end && spi_sck;   // Next bit goes out here
	assign last_bit = (bit_cnt == ($clog2($bits(spi_word_t)))'($bits(spi_word_t) - 1));

	////////////////////////////////////////
	// Control and pins

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state <= SPI_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
			spi_ready <= 1'b1;
			spi_scs <= 1'b1;
			spi_sck <= 1'b0;
			spi_sdo <= 1'b0;
		end else begin
			case (state)
				SPI_IDLE: begin
					if (spi_start) begin
						spi_ready <= 1'b0;
						spi_scs <= 1'b0;
						spi_sdo <= spi_word[$bits(spi_word_t)-1];  // MSB while sck low
						div_cnt <= '0;
						bit_cnt <= '0;
						state <= SPI_SHIFT;
					end
				end
				SPI_SHIFT: begin
					div_cnt <= half_end ? '0 : div_cnt + 1'b1;
					if (half_end && !spi_sck) begin
						spi_sck <= 1'b1;   // ADC samples on this edge
					end else if (sck_fall) begin
						spi_sck <= 1'b0;
						if (last_bit) begin
							spi_scs <= 1'b1;
							spi_sdo <= 1'b0;
							state <= SPI_DONE;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							spi_sdo <= shift_q[$bits(spi_word_t)-2];
						end
					end
				end
				default: begin   // SPI_DONE
					spi_ready <= 1'b1;
					state <= SPI_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_in) begin
		if (state == SPI_IDLE && spi_start)
			shift_q <= spi_word;
		else if (sck_fall)
			shift_q <= {shift_q[$bits(spi_word_t)-2:0], 1'b0};
	end

endmodule

`default_nettype wire

// ==== rtl/config_sequencer.sv ====
////////////////////////////////////////
// Configuration sequencer
// Power-up wait, ADC init writes, then host register writes
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module config_sequencer (
	input logic clk_in,
	input logic rst_in,
	input logic cmd_trig,
	input logic [15:0] cmd_addr,         // High byte selects the command
	input logic [7:0] cmd_data,
	input logic spi_ready,
	output logic spi_start,
	output adc_pkg::spi_word_t spi_word,
	output logic config_busy
);
	import adc_pkg::*;

	typedef enum logic [1:0] {
		SEQ_POWERUP,   // Let the ADC settle
		SEQ_START,     // Start pulse out, ready not yet low
		SEQ_XFER,      // Wait for the SPI master to finish
		SEQ_IDLE       // Accept host commands
	} seq_state_t;

	seq_state_t state;
	logic [$clog2(POWERUP_WAIT_CYCLES)-1:0] wait_cnt;
	logic [1:0] init_idx;   // Next init word, 3 when all are out
	logic cmd_write;

	// Fixed init words in order
	function automatic spi_word_t init_word(input logic [1:0] idx);
		case (idx)
			2'd0:    return INIT_WORD_RESET;
			2'd1:    return INIT_WORD_FORMAT;
			default: return INIT_WORD_LANES;
		endcase
	endfunction

	assign cmd_write = cmd_trig && (cmd_addr[15:8] == CMD_WRITE_PREFIX);

	////////////////////////////////////////
	// Sequencer state machine

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state <= SEQ_POWERUP;
			wait_cnt <= '0;
			init_idx <= 2'd0;
			spi_start <= 1'b0;
			config_busy <= 1'b1;   // Busy until the init writes are done
		end else begin
			case (state)
				SEQ_POWERUP: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == ($clog2(POWERUP_WAIT_CYCLES))'(POWERUP_WAIT_CYCLES - 1)) begin
						spi_start <= 1'b1;   // Soft reset goes first
						init_idx <= 2'd1;
						state <= SEQ_START;
					end
				end
				SEQ_START: begin
					spi_start <= 1'b0;
					state <= SEQ_XFER;
				end
				SEQ_XFER: begin
					if (spi_ready) begin
						if (init_idx != 2'd3) begin
							spi_start <= 1'b1;   // Next init word back to back
							init_idx <= init_idx + 1'b1;
							state <= SEQ_START;
						end else begin
							config_busy <= 1'b0;
							state <= SEQ_IDLE;
						end
					end
				end
				SEQ_IDLE: begin
					if (cmd_write) begin   // Other prefixes are dropped
						spi_start <= 1'b1;
						config_busy <= 1'b1;
						state <= SEQ_START;
					end
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	// Transfer word, loaded with each start
	always_ff @(posedge clk_in) begin
		if (state == SEQ_POWERUP ||
			(state == SEQ_XFER && spi_ready && init_idx != 2'd3))
			spi_word <= init_word(init_idx);
		else if (state == SEQ_IDLE && cmd_write)
			spi_word <= {1'b0, cmd_addr[6:0], cmd_data};  // Write flag low
	end

endmodule

`default_nettype wire

// ==== rtl/adc_receiver_top.sv ====
////////////////////////////////////////
// ADC receiver top
// Lane datapath and SPI configuration path for a 2-channel ADC
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module adc_receiver_top (
	input logic clk_in,
	input logic rst_in,
	input logic [4:0] lanes,            // Serial lanes, one bit per clock
	input logic cmd_trig,
	input logic [15:0] cmd_addr,
	input logic [7:0] cmd_data,
	output logic spi_scs,
	output logic spi_sck,
	output logic spi_sdo,
	output logic signed [15:0] adc0_sample,
	output logic signed [15:0] adc1_sample,
	output logic sample_valid,
	output logic aligned,
	output logic config_busy
);
	import adc_pkg::*;

	lane_word_if words_if ();   // Shared by all three stages

	logic spi_start;
	logic spi_ready;
	spi_word_t spi_word;

	////////////////////////////////////////
	// Datapath

	lane_deserializer deser0 (.clk_in, .rst_in, .lanes, .words(words_if.deser));

	frame_aligner aligner0 (.clk_in, .rst_in, .words(words_if.aligner));

	sample_unpacker unpacker0 (
		.clk_in, .rst_in,
		.words(words_if.unpacker),
		.adc0_sample, .adc1_sample, .sample_valid
	);

	assign aligned = words_if.aligned;

	////////////////////////////////////////
	// Control path

	config_sequencer seq0 (
		.clk_in, .rst_in,
		.cmd_trig, .cmd_addr, .cmd_data,
		.spi_ready, .spi_start, .spi_word, .config_busy
	);

	spi_master spi0 (
		.clk_in, .rst_in,
		.spi_start, .spi_word, .spi_ready,
		.spi_scs, .spi_sck, .spi_sdo
	);

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
////////////////////////////////////////
// Testbench clock generator
// Free running clock, 100 ns period
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 100
) (
	output logic clk_in
);

	initial begin
		clk_in = 1'b0;   // First rising edge half a period in
		forever #(PERIOD_NS / 2) clk_in = ~clk_in;
	end

endmodule

`default_nettype wire

// ==== sim/adc_lane_model.sv ====
////////////////////////////////////////
// ADC lane model
// Serializes frame pattern and counting samples onto five lanes
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module adc_lane_model (
	input logic clk_in,
	input logic enable,                     // Lanes idle low while clear
	input logic [2:0] bit_offset,           // Start position inside the first word
	input logic [15:0] first_sample,
	input logic [15:0] sample_step,
	output logic [adc_pkg::NUM_LANES-1:0] lanes
);
	import adc_pkg::*;

	logic [15:0] sample;    // ADC0 value of the current word
	logic [2:0] bit_pos;    // 0 sends word bit 7

	initial begin
		lanes = '0;
		sample = '0;
		bit_pos = '0;
	end

	////////////////////////////////////////
	// Serializer, MSB of each lane word first

	always @(negedge clk_in) begin : serialize
		logic [15:0] inv_sample;
		int b;
		if (!enable) begin
			lanes <= '0;
			bit_pos <= bit_offset;   // Partial first word shifts the boundary
			sample <= first_sample;
		end else begin
			b = LANE_BITS - 1 - bit_pos;   // Lane word bit sent now
			inv_sample = ~sample;          // ADC1 carries the inverse
			lanes[0] <= sample[2*b+1];     // Lo lane holds the odd bits
			lanes[1] <= sample[2*b];       // Hi lane holds the even bits
			lanes[2] <= inv_sample[2*b+1];
			lanes[3] <= inv_sample[2*b];
			lanes[4] <= FRAME_PATTERN[b];
			bit_pos <= bit_pos + 1'b1;
			if (bit_pos == 3'(LANE_BITS - 1))
				sample <= sample + sample_step;   // Next word, next sample
		end
	end

endmodule

`default_nettype wire

// ==== sim/adc_receiver_tb.sv ====
////////////////////////////////////////
// ADC receiver testbench
// Init writes, host commands, frame lock and sample checks
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module adc_receiver_tb;
	import adc_pkg::*;

	localparam logic [15:0] SAMPLE_STEP = 16'h0123;  // ADC0 increment per word
	localparam int QUIET_CYCLES = 400;                // No-transfer window and lock limit
	localparam int SAMPLE_CHECKS = 64;
	localparam int XFER_CYCLES = 2 * 16 * SPI_HALF_PERIOD + 4;
	// Twice the power-up, the transfers with slack, three quiet windows and the sample run
	localparam int WATCHDOG_CYCLES = 2 * (POWERUP_WAIT_CYCLES + 8 * XFER_CYCLES +
		3 * QUIET_CYCLES + SAMPLE_CHECKS * LANE_BITS);

	logic clk_in;
	logic rst_in;
	logic cmd_trig;
	logic [15:0] cmd_addr;
	logic [7:0] cmd_data;
	logic [4:0] lanes;
	logic spi_scs;
	logic spi_sck;
	logic spi_sdo;
	logic signed [15:0] adc0_sample;
	logic signed [15:0] adc1_sample;
	logic sample_valid;
	logic aligned;
	logic config_busy;

	logic model_en;
	logic [2:0] bit_offset;
	logic [15:0] first_sample;
	integer seed = 32'h09224efa;

	int cycle = 0;
	int act_cycle = 0;           // Cycle of the first lane activity
	int fail_count = 0;
	bit aligned_seen = 1'b0;
	int sample_count = 0;
	logic [15:0] prev_sample;
	logic [15:0] spi_words [$];  // Captured SPI transfers in order
	logic [15:0] spi_shift;
	int spi_bits = 0;

	tb_clock_gen clk_gen0 (.clk_in(clk_in));

	adc_lane_model model0 (
		.clk_in, .enable(model_en), .bit_offset, .first_sample,
		.sample_step(SAMPLE_STEP), .lanes
	);

	adc_receiver_top dut0 (
		.clk_in, .rst_in, .lanes, .cmd_trig, .cmd_addr, .cmd_data,
		.spi_scs, .spi_sck, .spi_sdo, .adc0_sample, .adc1_sample,
		.sample_valid, .aligned, .config_busy
	);

	////////////////////////////////////////
	// Error handling and helpers

	task automatic abort_run(input string what);
		fail_count++;
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else abort_run($sformatf("FAIL %s: expected %0h, actual %0h", name, expected, actual));
	endtask

	task automatic wait_for_words(input int count, input int limit, input string name);
		int waited;
		waited = 0;
		while (spi_words.size() < count) begin
			@(negedge clk_in);
			waited++;
			assert (waited <= limit)
			else abort_run({name, ": the expected SPI transfer never finished"});
		end
	endtask

	task automatic wait_for_idle(input int limit, input string name);
		int waited;
		waited = 0;
		while (config_busy !== 1'b0) begin
			@(negedge clk_in);
			waited++;
			assert (waited <= limit) else abort_run({name, ": config_busy stayed high"});
		end
	endtask

	// One-cycle host command driven between rising edges
	task automatic send_command(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk_in);
		cmd_trig = 1'b1;
		cmd_addr = addr;
		cmd_data = data;
		@(negedge clk_in);
		cmd_trig = 1'b0;
	endtask

	////////////////////////////////////////
	// Monitors

	always @(posedge clk_in)
		cycle <= cycle + 1;

	// Mode 0 SPI capture where sdo is stable at each sck rise
	always @(negedge spi_scs)
		spi_bits = 0;

	always @(posedge spi_sck) begin
		if (spi_scs === 1'b0) begin
			spi_shift = {spi_shift[14:0], spi_sdo};
			spi_bits++;
		end
	end

	always @(posedge spi_scs) begin
		if (spi_bits == 16)
			spi_words.push_back(spi_shift);
		else if (spi_bits != 0)   // Reset edge of scs carries no bits
			abort_run($sformatf("SPI transfer ended after %0d bits instead of 16", spi_bits));
		spi_bits = 0;
	end

	always @(negedge clk_in) begin : lock_monitor
		if (aligned_seen) begin
			assert (aligned === 1'b1) else abort_run("aligned fell again after lock");
		end else if (aligned === 1'b1) begin
			aligned_seen = 1'b1;
			assert (cycle - act_cycle <= QUIET_CYCLES)
			else abort_run($sformatf("FAIL lock_time: expected <= %0d, actual %0d",
				QUIET_CYCLES, cycle - act_cycle));
		end
	end

	always @(negedge clk_in) begin : sample_monitor
		logic [15:0] s0;
		logic [15:0] s1;
		logic [15:0] inv_s0;
		logic [15:0] next_s0;
		if (sample_valid === 1'b1) begin
			s0 = adc0_sample;
			s1 = adc1_sample;
			inv_s0 = ~s0;                          // Model sends ADC1 inverted
			next_s0 = prev_sample + SAMPLE_STEP;   // Wraps like the model
			assert (aligned === 1'b1) else abort_run("sample_valid pulsed before lock");
			check_equal("adc1_inverse", inv_s0, s1);
			if (sample_count > 0)
				check_equal("adc0_step", next_s0, s0);
			prev_sample = s0;
			sample_count++;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_in);
		abort_run("Watchdog expired before the tests finished");
	end

	////////////////////////////////////////
	// Test sequence

	initial begin : main_sequence
		int waited;
		rst_in = 1'b1;
		cmd_trig = 1'b0;
		cmd_addr = '0;
		cmd_data = '0;
		model_en = 1'b0;
		bit_offset = $random(seed) & 7;   // Random word boundary
		first_sample = $random(seed);
		$display("Lane offset %0d, first sample %h", bit_offset, first_sample);
		repeat (2) @(posedge clk_in);
		@(negedge clk_in);

		// Reset values
		check_equal("reset_scs", 1, spi_scs);
		check_equal("reset_sck", 0, spi_sck);
		check_equal("reset_sdo", 0, spi_sdo);
		check_equal("reset_spi_ready", 1, dut0.spi_ready);
		check_equal("reset_spi_start", 0, dut0.spi_start);
		check_equal("reset_word_valid", 0, dut0.words_if.word_valid);
		check_equal("reset_slip", 0, dut0.words_if.slip);
		check_equal("reset_sample_valid", 0, sample_valid);
		check_equal("reset_aligned", 0, aligned);
		check_equal("reset_config_busy", 1, config_busy);
		rst_in = 1'b0;
		model_en <= 1'b1;   // Model starts on the next falling edge
		act_cycle = cycle;

		// Power-up wait and then the init writes
		repeat (POWERUP_WAIT_CYCLES) @(negedge clk_in);
		check_equal("powerup_no_words", 0, spi_words.size());
		check_equal("powerup_scs_high", 1, spi_scs);
		wait_for_words(3, 4 * XFER_CYCLES, "init_writes");
		check_equal("init_word_reset", INIT_WORD_RESET, spi_words[0]);
		check_equal("init_word_format", INIT_WORD_FORMAT, spi_words[1]);
		check_equal("init_word_lanes", INIT_WORD_LANES, spi_words[2]);
		check_equal("init_busy_at_end", 1, config_busy);
		wait_for_idle(8, "init_busy_fall");

		// Host register write
		send_command(16'h3105, 8'hA5);
		check_equal("cmd_busy_rise", 1, config_busy);
		wait_for_words(4, 2 * XFER_CYCLES, "cmd_write");
		check_equal("cmd_write_word", 16'h05A5, spi_words[3]);
		wait_for_idle(8, "cmd_busy_fall");

		// Other prefix is dropped
		send_command(16'h3205, 8'h3C);
		repeat (QUIET_CYCLES) @(negedge clk_in);
		check_equal("cmd_other_prefix_words", 4, spi_words.size());
		check_equal("cmd_other_prefix_busy", 0, config_busy);

		// Second command lands while the first is still going
		send_command(16'h3107, 8'h11);
		check_equal("cmd_busy_before_second", 1, config_busy);
		send_command(16'h3109, 8'h22);
		wait_for_words(5, 2 * XFER_CYCLES, "cmd_first_of_two");
		check_equal("cmd_first_of_two_word", 16'h0711, spi_words[4]);
		wait_for_idle(8, "cmd_first_of_two_fall");
		repeat (QUIET_CYCLES) @(negedge clk_in);
		check_equal("cmd_while_busy_words", 5, spi_words.size());

		// Lock and sample stream are checked by the monitors
		waited = 0;
		while (!aligned_seen || sample_count < SAMPLE_CHECKS) begin
			@(negedge clk_in);
			waited++;
			assert (waited <= QUIET_CYCLES + SAMPLE_CHECKS * LANE_BITS)
			else abort_run("Too few samples arrived after lock");
		end

		if (fail_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			abort_run("Checks failed during the run");
		end
	end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/adc_pkg.sv
rtl/lane_word_if.sv
rtl/lane_deserializer.sv
rtl/frame_aligner.sv
rtl/sample_unpacker.sv
rtl/spi_master.sv
rtl/config_sequencer.sv
rtl/adc_receiver_top.sv
sim/tb_clock_gen.sv
sim/adc_lane_model.sv
sim/adc_receiver_tb.sv

// ==== Bender.yml ====
package:
  name: adc_receiver

sources:
  - rtl/adc_pkg.sv
  - rtl/lane_word_if.sv
  - rtl/lane_deserializer.sv
  - rtl/frame_aligner.sv
  - rtl/sample_unpacker.sv
  - rtl/spi_master.sv
  - rtl/config_sequencer.sv
  - rtl/adc_receiver_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/adc_lane_model.sv
      - sim/adc_receiver_tb.sv
